// File: common/board_defines.svh
// board glue widths and positions

`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// bus widths
`define BOARD_JOY_W        16   // joystick word from the board
`define GAME_JOY_W         10   // joystick word seen by the game
`define STATUS_W           32   // OSD status word
`define GFX_LAYERS         4

// set to 1 for games with a third fire button
`define THREE_BUTTONS      0

// positions inside a board joystick word
`define START1_BIT         (6 + `THREE_BUTTONS)
`define START2_BIT         (7 + `THREE_BUTTONS)
`define COIN_BIT           (8 + `THREE_BUTTONS)
`define PAUSE_BIT          (9 + `THREE_BUTTONS)

// 1 when the game expects active-low inputs
`define INPUTS_ACTIVE_LOW  1

// core reset length after the last cause, in clk_sys cycles
`define RST_HOLD_CYCLES    16

`endif

// File: common/board_pkg.sv
// board glue types

`include "board_defines.svh"

package board_pkg;

    // decoded keyboard state, already in the clk_sys domain
    typedef struct packed {
        logic [`GAME_JOY_W-1:0] joy1;
        logic [`GAME_JOY_W-1:0] joy2;
        logic [1:0]             start;
        logic [1:0]             coin;
        logic                   reset;    // soft reset key
        logic                   pause;
        logic                   service;
        logic [`GFX_LAYERS-1:0] gfx;      // layer toggle keys
    } key_state_t;

    // what the game core sees
    typedef struct packed {
        logic [`GAME_JOY_W-1:0] joystick1;
        logic [`GAME_JOY_W-1:0] joystick2;
        logic [1:0]             coin;
        logic [1:0]             start;
        logic                   service;
    } game_inputs_t;

    // settings decoded from the OSD status word
    typedef struct packed {
        logic [1:0] rotate;
        logic       rot_control;
        logic       enable_fm;
        logic       enable_psg;
        logic       dip_test;
        logic       dip_pause;
        logic       dip_flip;      // a change here restarts the core
        logic [1:0] fxlevel;
        logic [2:0] scanlines;     // passed on to the video frame
    } dip_cfg_t;

    // core reset sequencer
    typedef enum logic {
        RST_IDLE = 1'b0,
        RST_HOLD = 1'b1
    } rst_state_e;

endpackage

// File: design/reset_seq.sv
// core reset stretcher

`timescale 1ns/10ps
`include "board_defines.svh"

module reset_seq (
    input  logic clk_sys,
    input  logic game_rst,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic dip_flip,
    output logic core_rst
);
    import board_pkg::*;

    localparam int CNT_W = $clog2(`RST_HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RST_HOLD_CYCLES - 1);

    rst_state_e       state;
    logic [CNT_W-1:0] hold_cnt;   // quiet cycles seen so far
    logic             flip_q;     // local copy of dip_flip
    logic             flip_prev;  // one sample older
    logic             cause;

    // screen flip change counts as a reset request
    assign cause = rst_req | soft_rst | (flip_q != flip_prev);

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            state     <= RST_HOLD;
            hold_cnt  <= '0;
            flip_q    <= 1'b0;
            flip_prev <= 1'b0;
        end else begin
            flip_q    <= dip_flip;
            flip_prev <= flip_q;
            case (state)
                RST_IDLE: begin
                    if (cause) begin
                        state    <= RST_HOLD;
                        hold_cnt <= '0;
                    end
                end
                RST_HOLD: begin
                    if (cause) begin
                        hold_cnt <= '0;           // restart the stretch
                    end else if (hold_cnt == CNT_LAST) begin
                        state <= RST_IDLE;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign core_rst = (state == RST_HOLD);    // straight from the state flop

endmodule

// File: design/dip_decode.sv
// OSD status decoder

`timescale 1ns/10ps
`include "board_defines.svh"

module dip_decode (
    input  logic                  clk_sys,
    input  logic                  game_rst,
    input  logic [`STATUS_W-1:0]  status,
    input  logic                  game_pause,
    output board_pkg::dip_cfg_t   dip
);
    import board_pkg::*;

    dip_cfg_t dip_next;

    always_comb begin
        dip_next             = '0;
        dip_next.rotate      = status[2:1];
        dip_next.rot_control = status[2];       // shares a bit with rotate
        dip_next.dip_flip    = status[3];
        dip_next.dip_test    = status[4];
        dip_next.enable_fm   = ~status[5];      // OSD stores a disable
        dip_next.enable_psg  = ~status[6];
        dip_next.fxlevel     = status[8:7];
        dip_next.scanlines   = status[11:9];
        // the OSD bit and the pause toggle both freeze the game
        dip_next.dip_pause   = game_pause | status[0];
    end

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            dip            <= '0;
            dip.enable_fm  <= 1'b1;   // sound on by default
            dip.enable_psg <= 1'b1;
        end else begin
            dip <= dip_next;
        end
    end

endmodule

// File: input/input_mapper.sv
// joystick and key input mapper

`timescale 1ns/10ps
`include "board_defines.svh"

module input_mapper (
    input  logic                     clk_sys,
    input  logic                     game_rst,
    input  logic [`BOARD_JOY_W-1:0]  board_joystick1,  // async, active high
    input  logic [`BOARD_JOY_W-1:0]  board_joystick2,
    input  board_pkg::key_state_t    keys,
    input  logic                     rot_control,
    output board_pkg::game_inputs_t  inputs,
    output logic                     joy_pause
);
    import board_pkg::*;

    localparam logic INV = (`INPUTS_ACTIVE_LOW != 0);
    localparam logic [`GAME_JOY_W-1:0] INV_JOY  = {`GAME_JOY_W{INV}};
    localparam logic [1:0]             INV_PAIR = {2{INV}};

    logic [`BOARD_JOY_W-1:0] joy1_sync;
    logic [`BOARD_JOY_W-1:0] joy2_sync;
    logic [`GAME_JOY_W-1:0]  joy1_merged;
    logic [`GAME_JOY_W-1:0]  joy2_merged;
    game_inputs_t            inputs_next;

    // quarter turn for vertical games on a horizontal screen
    function automatic logic [`GAME_JOY_W-1:0] apply_rot(
        input logic [`GAME_JOY_W-1:0] joy,
        input logic                   rot
    );
        logic [`GAME_JOY_W-1:0] res;
        res = joy;
        if (rot) begin
            res[3:0] = {joy[0], joy[1], joy[3], joy[2]};
        end
        return res;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            joy1_sync <= '0;
            joy2_sync <= '0;
        end else begin
            joy1_sync <= board_joystick1;   // single sync stage
            joy2_sync <= board_joystick2;
        end
    end

    assign joy1_merged = joy1_sync[`GAME_JOY_W-1:0] | keys.joy1;
    assign joy2_merged = joy2_sync[`GAME_JOY_W-1:0] | keys.joy2;

    always_comb begin
        inputs_next.joystick1 = INV_JOY ^ apply_rot(joy1_merged, rot_control);
        inputs_next.joystick2 = INV_JOY ^ apply_rot(joy2_merged, rot_control);
        inputs_next.coin      = INV_PAIR ^
            ({joy2_sync[`COIN_BIT], joy1_sync[`COIN_BIT]} | keys.coin);
        // either joystick can press either start button
        inputs_next.start     = INV_PAIR ^
            ({joy1_sync[`START2_BIT], joy1_sync[`START1_BIT]} |
             {joy2_sync[`START2_BIT], joy2_sync[`START1_BIT]} | keys.start);
        inputs_next.service   = INV ^ keys.service;
    end

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            inputs.joystick1 <= INV_JOY;    // nothing pressed
            inputs.joystick2 <= INV_JOY;
            inputs.coin      <= INV_PAIR;
            inputs.start     <= INV_PAIR;
            inputs.service   <= INV;
            joy_pause        <= 1'b0;
        end else begin
            inputs    <= inputs_next;
            joy_pause <= joy1_sync[`PAUSE_BIT] | joy2_sync[`PAUSE_BIT];
        end
    end

endmodule

// File: input/input_toggles.sv
// pause, layer and soft reset toggles

`timescale 1ns/10ps
`include "board_defines.svh"

module input_toggles (
    input  logic                    clk_sys,
    input  logic                    game_rst,
    input  board_pkg::key_state_t   keys,
    input  logic                    joy_pause,
    output logic                    game_pause,
    output logic [`GFX_LAYERS-1:0]  gfx_en,
    output logic                    soft_rst
);
    import board_pkg::*;

    logic                   last_pause_key;  // previous key samples
    logic                   last_joy_pause;
    logic                   last_reset_key;
    logic [`GFX_LAYERS-1:0] last_gfx_keys;
    logic                   pause_press;
    logic                   reset_press;
    logic [`GFX_LAYERS-1:0] gfx_press;

    assign pause_press = (keys.pause & ~last_pause_key) |
                         (joy_pause & ~last_joy_pause);
    assign reset_press = keys.reset & ~last_reset_key;
    assign gfx_press   = keys.gfx & ~last_gfx_keys;

    always_ff @(posedge clk_sys) begin
        // a key held through reset is not a new press
        last_pause_key <= keys.pause;
        last_joy_pause <= joy_pause;
        last_reset_key <= keys.reset;
        last_gfx_keys  <= keys.gfx;
        if (game_rst) begin
            game_pause <= 1'b0;
            gfx_en     <= '1;                   // all layers on
            soft_rst   <= 1'b0;
        end else begin
            soft_rst <= reset_press;           // one cycle wide
            if (pause_press) begin
                game_pause <= ~game_pause;
            end
            for (int i = 0; i < `GFX_LAYERS; i++) begin
                if (gfx_press[i]) begin
                    gfx_en[i] <= ~gfx_en[i];
                end
            end
        end
    end

endmodule

// File: design/board_top.sv
// arcade board glue top

`timescale 1ns/10ps
`include "board_defines.svh"

module board_top (
    input  logic                     clk_sys,
    input  logic                     game_rst,
    input  logic                     rst_req,      // level, held by the frame
    input  logic [`BOARD_JOY_W-1:0]  board_joystick1,
    input  logic [`BOARD_JOY_W-1:0]  board_joystick2,
    input  board_pkg::key_state_t    keys,
    input  logic [`STATUS_W-1:0]     status,
    output logic                     core_rst,
    output board_pkg::game_inputs_t  inputs,
    output board_pkg::dip_cfg_t      dip,
    output logic                     game_pause,
    output logic [`GFX_LAYERS-1:0]   gfx_en
);

    logic joy_pause;    // pause button on either joystick
    logic soft_rst;     // one cycle per reset key press

    reset_seq u_reset_seq (
        .clk_sys  (clk_sys),
        .game_rst (game_rst),
        .rst_req  (rst_req),
        .soft_rst (soft_rst),
        .dip_flip (dip.dip_flip),
        .core_rst (core_rst)
    );

    dip_decode u_dip_decode (
        .clk_sys    (clk_sys),
        .game_rst   (game_rst),
        .status     (status),
        .game_pause (game_pause),
        .dip        (dip)
    );

    input_mapper u_input_mapper (
        .clk_sys         (clk_sys),
        .game_rst        (game_rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .keys            (keys),
        .rot_control     (dip.rot_control),
        .inputs          (inputs),
        .joy_pause       (joy_pause)
    );

    input_toggles u_input_toggles (
        .clk_sys    (clk_sys),
        .game_rst   (game_rst),
        .keys       (keys),
        .joy_pause  (joy_pause),
        .game_pause (game_pause),
        .gfx_en     (gfx_en),
        .soft_rst   (soft_rst)
    );

endmodule

// File: verification/tb_board.sv
// board glue testbench

`timescale 1ns/10ps
`include "board_defines.svh"

module tb_board;
    import board_pkg::*;

    localparam int   MAX_CYCLES = 2000;     // several times the full run
    localparam int   HOLD       = `RST_HOLD_CYCLES;
    localparam logic ACTIVE_LOW = (`INPUTS_ACTIVE_LOW != 0);

    logic                    clk_sys = 1'b0;
    logic                    game_rst;
    logic                    rst_req;
    logic [`BOARD_JOY_W-1:0] board_joystick1;
    logic [`BOARD_JOY_W-1:0] board_joystick2;
    key_state_t              keys;
    logic [`STATUS_W-1:0]    status;
    logic                    core_rst;
    game_inputs_t            inputs;
    dip_cfg_t                dip;
    logic                    game_pause;
    logic [`GFX_LAYERS-1:0]  gfx_en;

    integer seed;
    int     cycle_count = 0;
    int     err_count = 0;

    // inputs seen at earlier falling edges, index 1 is one cycle back
    key_state_t              h_keys   [1:2];
    logic [`BOARD_JOY_W-1:0] h_joy1   [1:2];
    logic [`BOARD_JOY_W-1:0] h_joy2   [1:2];
    logic [`STATUS_W-1:0]    h_status [1:4];
    logic                    h_rst    [1:2];
    logic                    h_req;

    // model registers
    logic                   m_pause;
    logic [`GFX_LAYERS-1:0] m_gfx;
    logic                   m_soft;
    logic                   m_joyp;
    logic                   m_joyp_prev;
    int                     m_quiet;     // cycles since the last reset cause

    board_top u_dut (
        .clk_sys         (clk_sys),
        .game_rst        (game_rst),
        .rst_req         (rst_req),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .keys            (keys),
        .status          (status),
        .core_rst        (core_rst),
        .inputs          (inputs),
        .dip             (dip),
        .game_pause      (game_pause),
        .gfx_en          (gfx_en)
    );

    initial begin
        forever #4 clk_sys = ~clk_sys;
    end

    function automatic logic [`GAME_JOY_W-1:0] exp_rot(
        input logic [`GAME_JOY_W-1:0] joy,
        input logic                   rot
    );
        logic [`GAME_JOY_W-1:0] res;
        res = joy;
        if (rot) begin
            res[3] = joy[0];
            res[2] = joy[1];
            res[1] = joy[3];
            res[0] = joy[2];
        end
        return res;
    endfunction

    function automatic game_inputs_t exp_inputs(
        input logic [`BOARD_JOY_W-1:0] j1,
        input logic [`BOARD_JOY_W-1:0] j2,
        input key_state_t              k,
        input logic                    rot
    );
        game_inputs_t r;
        r.joystick1 = exp_rot(j1[`GAME_JOY_W-1:0] | k.joy1, rot) ^ {`GAME_JOY_W{ACTIVE_LOW}};
        r.joystick2 = exp_rot(j2[`GAME_JOY_W-1:0] | k.joy2, rot) ^ {`GAME_JOY_W{ACTIVE_LOW}};
        r.coin[0]   = j1[`COIN_BIT] | k.coin[0];
        r.coin[1]   = j2[`COIN_BIT] | k.coin[1];
        r.start[0]  = j1[`START1_BIT] | j2[`START1_BIT] | k.start[0];
        r.start[1]  = j1[`START2_BIT] | j2[`START2_BIT] | k.start[1];
        r.coin      = r.coin ^ {2{ACTIVE_LOW}};
        r.start     = r.start ^ {2{ACTIVE_LOW}};
        r.service   = k.service ^ ACTIVE_LOW;
        return r;
    endfunction

    function automatic dip_cfg_t exp_dip(input logic [`STATUS_W-1:0] s, input logic pause);
        dip_cfg_t d;
        d.rotate      = s[2:1];
        d.rot_control = s[2];
        d.enable_fm   = ~s[5];
        d.enable_psg  = ~s[6];
        d.dip_test    = s[4];
        d.dip_pause   = pause | s[0];
        d.dip_flip    = s[3];
        d.fxlevel     = s[8:7];
        d.scanlines   = s[11:9];
        return d;
    endfunction

    task automatic stop_failed();
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        err_count++;
        $display("** Error at %0t: %s is %h, expected %h", $time, what, got, want);
        stop_failed();
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else report_mismatch(what, got, want);
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic cycles_until_core_rst(input logic level, output int n);
        n = 0;
        while (core_rst !== level) begin
            if (n > 4 * HOLD) begin
                $display("core_rst did not go to %0b within %0d cycles", level, n);
                stop_failed();
            end else begin
                next_cycle();
                n++;
            end
        end
    endtask

    // let pending flip changes land, then wait for the core to run
    task automatic settle();
        int n;
        repeat (4) next_cycle();
        cycles_until_core_rst(1'b0, n);
    endtask

    task automatic drive_random_inputs(input logic rot);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        board_joystick1 = r1[`BOARD_JOY_W-1:0];
        board_joystick2 = r1[31:32-`BOARD_JOY_W];
        keys            = r2[30:0];
        keys.reset      = 1'b0;          // soft reset has its own test
        status          = {r3[31:3], rot, r3[1:0]};
    endtask

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            stop_failed();
        end
    end

    initial begin
        h_keys[1] = '0;
        h_keys[2] = '0;
        h_joy1[1] = '0;
        h_joy1[2] = '0;
        h_joy2[1] = '0;
        h_joy2[2] = '0;
        for (int i = 1; i <= 4; i++) begin
            h_status[i] = '0;
        end
        h_rst[1]    = 1'b1;
        h_rst[2]    = 1'b1;
        h_req       = 1'b0;
        m_pause     = 1'b0;
        m_gfx       = '1;
        m_soft      = 1'b0;
        m_joyp      = 1'b0;
        m_joyp_prev = 1'b0;
        m_quiet     = HOLD;
    end

    // outputs settled half a cycle after the edge
    always @(negedge clk_sys) begin : compare
        game_inputs_t           e_inputs;
        dip_cfg_t               e_dip;
        logic                   press;
        logic                   cause;
        logic                   joyp_new;
        logic                   soft_new;
        logic                   pause_new;
        logic [`GFX_LAYERS-1:0] gfx_new;

        if (h_rst[1]) begin
            e_dip            = '0;
            e_dip.enable_fm  = 1'b1;
            e_dip.enable_psg = 1'b1;
            e_inputs         = exp_inputs('0, '0, '0, 1'b0);   // nothing pressed
        end else begin
            e_dip = exp_dip(h_status[1], m_pause);
            if (h_rst[2]) begin
                e_inputs = exp_inputs('0, '0, h_keys[1], 1'b0);
            end else begin
                e_inputs = exp_inputs(h_joy1[2], h_joy2[2], h_keys[1], h_status[2][2]);
            end
        end

        press    = (h_keys[1].pause & ~h_keys[2].pause) | (m_joyp & ~m_joyp_prev);
        joyp_new = (h_rst[1] | h_rst[2]) ? 1'b0 :
                   (h_joy1[2][`PAUSE_BIT] | h_joy2[2][`PAUSE_BIT]);
        pause_new = h_rst[1] ? 1'b0 : (m_pause ^ press);
        gfx_new   = h_rst[1] ? '1 : (m_gfx ^ (h_keys[1].gfx & ~h_keys[2].gfx));
        soft_new  = h_rst[1] ? 1'b0 : (h_keys[1].reset & ~h_keys[2].reset);

        // flip difference reaches the sequencer three cycles after status
        cause = h_rst[1] | h_req | m_soft | (h_status[3][3] ^ h_status[4][3]);
        if (cause) begin
            m_quiet = 0;
        end else if (m_quiet < HOLD) begin
            m_quiet++;
        end

        check_value("core_rst", 32'(core_rst), 32'(m_quiet < HOLD));
        check_value("inputs", 32'(inputs), 32'(e_inputs));
        check_value("dip", 32'(dip), 32'(e_dip));
        check_value("game_pause", 32'(game_pause), 32'(pause_new));
        check_value("gfx_en", 32'(gfx_en), 32'(gfx_new));

        m_pause     = pause_new;
        m_gfx       = gfx_new;
        m_soft      = soft_new;
        m_joyp_prev = m_joyp;
        m_joyp      = joyp_new;

        h_keys[2] = h_keys[1];
        h_keys[1] = keys;
        h_joy1[2] = h_joy1[1];
        h_joy1[1] = board_joystick1;
        h_joy2[2] = h_joy2[1];
        h_joy2[1] = board_joystick2;
        for (int i = 4; i > 1; i--) begin
            h_status[i] = h_status[i-1];
        end
        h_status[1] = status;
        h_rst[2]    = h_rst[1];
        h_rst[1]    = game_rst;
        h_req       = rst_req;
    end

    initial begin : stimulus
        int                     n;
        logic                   pause_before;
        logic [`GFX_LAYERS-1:0] gfx_before;
        logic [31:0]            r;

        seed            = 32'h60e7_8a3f;
        game_rst        = 1'b1;
        rst_req         = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        keys            = '0;
        status          = '0;
        repeat (5) next_cycle();
        game_rst = 1'b0;

        // core reset stretch after game_rst and after a request pulse
        cycles_until_core_rst(1'b0, n);
        check_value("core_rst hold after game_rst", 32'(n), 32'(HOLD));
        rst_req = 1'b1;
        next_cycle();
        rst_req = 1'b0;
        check_value("core_rst after rst_req", 32'(core_rst), 32'd1);
        cycles_until_core_rst(1'b0, n);
        check_value("core_rst hold after rst_req", 32'(n), 32'(HOLD));

        // random joysticks and keys, rotation switched every 25 words
        for (int i = 0; i < 200; i++) begin
            drive_random_inputs(((i / 25) % 2) == 1);
            next_cycle();
        end
        board_joystick1 = '0;
        board_joystick2 = '0;
        keys            = '0;
        status          = '0;
        settle();

        // coin, start and service
        board_joystick1[`COIN_BIT]   = 1'b1;
        board_joystick2[`START2_BIT] = 1'b1;
        repeat (3) next_cycle();
        check_value("coin from joystick 1", 32'(inputs.coin), 32'(2'b01 ^ {2{ACTIVE_LOW}}));
        check_value("start from joystick 2", 32'(inputs.start), 32'(2'b10 ^ {2{ACTIVE_LOW}}));
        board_joystick1 = '0;
        board_joystick2 = '0;
        keys.coin       = 2'b10;
        keys.start      = 2'b01;
        keys.service    = 1'b1;
        repeat (2) next_cycle();
        check_value("service from keys", 32'(inputs.service), 32'(!ACTIVE_LOW));
        keys = '0;
        repeat (3) next_cycle();

        // pause from a held key, then from a held joystick button
        pause_before = m_pause;
        keys.pause = 1'b1;
        repeat (6) next_cycle();
        check_value("game_pause after key hold", 32'(game_pause), 32'(!pause_before));
        check_value("dip_pause", 32'(dip.dip_pause), 32'(!pause_before));
        keys.pause = 1'b0;
        repeat (2) next_cycle();
        pause_before = m_pause;
        board_joystick2[`PAUSE_BIT] = 1'b1;
        repeat (6) next_cycle();
        check_value("game_pause after joystick hold", 32'(game_pause), 32'(!pause_before));
        board_joystick2 = '0;
        repeat (4) next_cycle();
        gfx_before = m_gfx;
        keys.gfx = 4'b0101;
        repeat (2) next_cycle();
        keys.gfx = '0;
        next_cycle();
        check_value("gfx_en toggles", 32'(gfx_en), 32'(gfx_before ^ 4'b0101));
        repeat (3) next_cycle();

        // soft reset key and screen flip
        settle();
        keys.reset = 1'b1;
        cycles_until_core_rst(1'b1, n);
        check_value("core_rst delay after reset key", 32'(n), 32'd2);
        keys.reset = 1'b0;
        cycles_until_core_rst(1'b0, n);
        check_value("core_rst hold after reset key", 32'(n), 32'(HOLD));
        status[3] = ~status[3];
        cycles_until_core_rst(1'b1, n);
        check_value("core_rst delay after flip", 32'(n), 32'd3);
        cycles_until_core_rst(1'b0, n);
        check_value("core_rst hold after flip", 32'(n), 32'(HOLD));

        // random status words
        for (int i = 0; i < 50; i++) begin
            r = $random(seed);
            status = r;
            next_cycle();
        end
        status = '0;
        settle();

        if (err_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            stop_failed();
        end
    end

endmodule

// File: list.f
+incdir+common
common/board_pkg.sv
design/reset_seq.sv
design/dip_decode.sv
input/input_mapper.sv
input/input_toggles.sv
design/board_top.sv
verification/tb_board.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the board glue testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_board -o sim_board
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/sim_board 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "test passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
